// File: logic/stats_pkg.sv
// shared widths, MDIO frame union and PHY init write table
`default_nettype none

package stats_pkg;

// statistics path
localparam int STAT_SOURCES = 3;
localparam int STAT_ID_W = 6;
localparam int STAT_INC_W = 16;
localparam int STAT_COUNT_W = 32;
localparam int AXIL_ADDR_W = 8;

// clause 22 frame codes
localparam logic [4:0] MDIO_PHY_ADDR = 5'd3;
localparam logic [1:0] MDIO_ST_C22 = 2'b01;
localparam logic [1:0] MDIO_OP_WRITE = 2'b01;
localparam logic [1:0] MDIO_TA = 2'b10;

// one write frame, built as fields and shifted as a word
typedef union packed {
    struct packed {
        logic [1:0]  st;
        logic [1:0]  op;
        logic [4:0]  phy_addr;
        logic [4:0]  reg_addr;
        logic [1:0]  ta;
        logic [15:0] data;
    } f;
    logic [31:0] raw;
} mdio_frame_t;

// extended register access goes through REGCR/ADDAR
localparam logic [4:0] PHY_REG_REGCR = 5'h0D;
localparam logic [4:0] PHY_REG_ADDAR = 5'h0E;
localparam int PHY_INIT_STEPS = 12;

// each entry is {register, data}
localparam logic [20:0] phy_init_table [PHY_INIT_STEPS] = '{
    // CFG4 (0x0031) = 0x0070, SGMII autoneg timer
    {PHY_REG_REGCR, 16'h001F},
    {PHY_REG_ADDAR, 16'h0031},
    {PHY_REG_REGCR, 16'h401F},
    {PHY_REG_ADDAR, 16'h0070},
    // SGMIICTL1 (0x00D3) = 0x4000, SGMII clock out
    {PHY_REG_REGCR, 16'h001F},
    {PHY_REG_ADDAR, 16'h00D3},
    {PHY_REG_REGCR, 16'h401F},
    {PHY_REG_ADDAR, 16'h4000},
    // 10M_SGMII_CFG (0x016F) = 0x0015
    {PHY_REG_REGCR, 16'h001F},
    {PHY_REG_ADDAR, 16'h016F},
    {PHY_REG_REGCR, 16'h401F},
    {PHY_REG_ADDAR, 16'h0015}
};

endpackage

`default_nettype wire

// File: logic/stat_rr_arbiter.sv
// stat_rr_arbiter: round-robin merge of statistics increment channels
`timescale 1ns/1ns
`default_nettype none

module stat_rr_arbiter (
    input  wire logic                                                   clk_125mhz,
    input  wire logic                                                   rst_125mhz,

    input  wire logic [stats_pkg::STAT_SOURCES-1:0]                     stat_valid,
    output wire logic [stats_pkg::STAT_SOURCES-1:0]                     stat_ready,
    input  wire logic [stats_pkg::STAT_SOURCES-1:0][stats_pkg::STAT_ID_W-1:0]  stat_id,
    input  wire logic [stats_pkg::STAT_SOURCES-1:0][stats_pkg::STAT_INC_W-1:0] stat_inc,

    output wire logic                                                   arb_valid,
    input  wire logic                                                   arb_ready,
    output wire logic [stats_pkg::STAT_ID_W-1:0]                        arb_id,
    output wire logic [stats_pkg::STAT_INC_W-1:0]                       arb_inc
);

import stats_pkg::*;

localparam int PTR_W = (STAT_SOURCES > 1) ? $clog2(STAT_SOURCES) : 1;

logic [PTR_W-1:0] rr_ptr_reg;
logic out_valid_reg;
logic [STAT_ID_W-1:0] out_id_reg;
logic [STAT_INC_W-1:0] out_inc_reg;

logic load;
logic grant_found;
logic [PTR_W-1:0] grant_idx;

// output register empty or draining this cycle
assign load = !out_valid_reg || arb_ready;

// first requester at or after the pointer
always_comb begin
    grant_found = 1'b0;
    grant_idx = '0;
    for (int i = 0; i < STAT_SOURCES; i++) begin
        if (!grant_found && stat_valid[(int'(rr_ptr_reg) + i) % STAT_SOURCES]) begin
            grant_found = 1'b1;
            grant_idx = PTR_W'((int'(rr_ptr_reg) + i) % STAT_SOURCES);
        end
    end
end

assign stat_ready = (load && grant_found) ? (STAT_SOURCES'(1) << grant_idx) : '0;

always_ff @(posedge clk_125mhz) begin
    if (load) begin
        out_valid_reg <= grant_found;
        if (grant_found) begin
            // priority moves past the winner
            rr_ptr_reg <= (int'(grant_idx) == STAT_SOURCES - 1) ? '0 : grant_idx + 1'b1;
        end
    end

    if (rst_125mhz) begin
        out_valid_reg <= 1'b0;
        rr_ptr_reg <= '0;
    end
end

// payload only
always_ff @(posedge clk_125mhz) begin
    if (load && grant_found) begin
        out_id_reg <= stat_id[grant_idx];
        out_inc_reg <= stat_inc[grant_idx];
    end
end

assign arb_valid = out_valid_reg;
assign arb_id = out_id_reg;
assign arb_inc = out_inc_reg;

endmodule

`default_nettype wire

// File: logic/stat_counter_mem.sv
// stat_counter_mem: counter RAM with RMW pipeline, clear sweep and AXI4-Lite read
`timescale 1ns/1ns
`default_nettype none

module stat_counter_mem (
    input  wire logic                               clk_125mhz,
    input  wire logic                               rst_125mhz,

    input  wire logic                               arb_valid,
    output wire logic                               arb_ready,
    input  wire logic [stats_pkg::STAT_ID_W-1:0]    arb_id,
    input  wire logic [stats_pkg::STAT_INC_W-1:0]   arb_inc,

    input  wire logic [stats_pkg::AXIL_ADDR_W-1:0]  s_axil_araddr,
    input  wire logic                               s_axil_arvalid,
    output wire logic                               s_axil_arready,
    output wire logic [stats_pkg::STAT_COUNT_W-1:0] s_axil_rdata,
    output wire logic [1:0]                         s_axil_rresp,
    output wire logic                               s_axil_rvalid,
    input  wire logic                               s_axil_rready
);

import stats_pkg::*;

localparam int DEPTH = 2**STAT_ID_W;

logic [STAT_COUNT_W-1:0] mem [DEPTH];

logic clear_active_reg;
logic [STAT_ID_W-1:0] clear_idx_reg;
logic resp_pending_reg;
logic rvalid_reg;
logic [STAT_COUNT_W-1:0] rdata_reg;

// stage 1 holds an increment or a read
logic s1_inc_valid_reg;
logic s1_rd_valid_reg;
logic [STAT_ID_W-1:0] s1_id_reg;
logic [STAT_INC_W-1:0] s1_inc_reg;
logic [STAT_COUNT_W-1:0] rd_data_reg;

// last write, for forwarding
logic wb_valid_reg;
logic [STAT_ID_W-1:0] wb_id_reg;
logic [STAT_COUNT_W-1:0] wb_data_reg;

logic ar_hs;
logic inc_hs;
logic [STAT_ID_W-1:0] rd_addr;
logic [STAT_COUNT_W-1:0] old_val;
logic [STAT_COUNT_W-1:0] new_val;

assign s_axil_arready = !clear_active_reg && !resp_pending_reg;
assign ar_hs = s_axil_arvalid && s_axil_arready;

// a read takes the RAM port in its handshake cycle
assign arb_ready = !clear_active_reg && !ar_hs;
assign inc_hs = arb_valid && arb_ready;

assign rd_addr = ar_hs ? s_axil_araddr[STAT_ID_W+1:2] : arb_id;

// RAM read misses a write landing on the same edge
assign old_val = (wb_valid_reg && wb_id_reg == s1_id_reg) ? wb_data_reg : rd_data_reg;
assign new_val = old_val + STAT_COUNT_W'(s1_inc_reg);

always_ff @(posedge clk_125mhz) begin
    rd_data_reg <= mem[rd_addr];
    s1_id_reg <= rd_addr;
    s1_inc_reg <= arb_inc;
    wb_id_reg <= s1_id_reg;
    wb_data_reg <= new_val;

    if (clear_active_reg) begin
        mem[clear_idx_reg] <= '0;
    end else if (s1_inc_valid_reg) begin
        mem[s1_id_reg] <= new_val;
    end

    if (s1_rd_valid_reg) begin
        rdata_reg <= old_val;
    end
end

always_ff @(posedge clk_125mhz) begin
    s1_inc_valid_reg <= inc_hs;
    s1_rd_valid_reg <= ar_hs;
    wb_valid_reg <= s1_inc_valid_reg;

    if (clear_active_reg) begin
        clear_idx_reg <= clear_idx_reg + 1'b1;
        if (&clear_idx_reg) begin
            clear_active_reg <= 1'b0;
        end
    end

    if (rvalid_reg && s_axil_rready) begin
        rvalid_reg <= 1'b0;
        resp_pending_reg <= 1'b0;
    end
    if (ar_hs) begin
        resp_pending_reg <= 1'b1;
    end
    if (s1_rd_valid_reg) begin
        rvalid_reg <= 1'b1;
    end

    if (rst_125mhz) begin
        clear_active_reg <= 1'b1;
        clear_idx_reg <= '0;
        s1_inc_valid_reg <= 1'b0;
        s1_rd_valid_reg <= 1'b0;
        wb_valid_reg <= 1'b0;
        resp_pending_reg <= 1'b0;
        rvalid_reg <= 1'b0;
    end
end

assign s_axil_rdata = rdata_reg;
assign s_axil_rresp = 2'b00;
assign s_axil_rvalid = rvalid_reg;

endmodule

`default_nettype wire

// File: logic/phy_init_sequencer.sv
// phy_init_sequencer: start-up delay and PHY init MDIO write list
`timescale 1ns/1ns
`default_nettype none

module phy_init_sequencer #(
    parameter int INIT_DELAY = 1000000
) (
    input  wire logic                   clk_125mhz,
    input  wire logic                   rst_125mhz,

    output wire logic                   cmd_valid,
    input  wire logic                   cmd_ready,
    output wire stats_pkg::mdio_frame_t cmd_frame
);

import stats_pkg::*;

localparam int DELAY_W = $clog2(INIT_DELAY + 1);
localparam int STEP_W = $clog2(PHY_INIT_STEPS + 1);

logic [DELAY_W-1:0] delay_cnt_reg;
logic [STEP_W-1:0] step_reg;
logic cmd_valid_reg;
mdio_frame_t frame_reg;

logic load;

// next step once the delay ran out and the last one was taken
assign load = (delay_cnt_reg == '0) && !cmd_valid_reg &&
    (step_reg < STEP_W'(PHY_INIT_STEPS));

always_ff @(posedge clk_125mhz) begin
    cmd_valid_reg <= cmd_valid_reg && !cmd_ready;

    if (delay_cnt_reg != '0) begin
        delay_cnt_reg <= delay_cnt_reg - 1'b1;
    end

    if (load) begin
        cmd_valid_reg <= 1'b1;
        step_reg <= step_reg + 1'b1;
    end

    if (rst_125mhz) begin
        delay_cnt_reg <= DELAY_W'(INIT_DELAY);
        step_reg <= '0;
        cmd_valid_reg <= 1'b0;
    end
end

// fill the field view
always_ff @(posedge clk_125mhz) begin
    if (load) begin
        frame_reg.f.st <= MDIO_ST_C22;
        frame_reg.f.op <= MDIO_OP_WRITE;
        frame_reg.f.phy_addr <= MDIO_PHY_ADDR;
        frame_reg.f.reg_addr <= phy_init_table[step_reg][20:16];
        frame_reg.f.ta <= MDIO_TA;
        frame_reg.f.data <= phy_init_table[step_reg][15:0];
    end
end

assign cmd_valid = cmd_valid_reg;
assign cmd_frame = frame_reg;

endmodule

`default_nettype wire

// File: logic/mdio_master.sv
// mdio_master: clause-22 write frame shifter with MDC divider
`timescale 1ns/1ns
`default_nettype none

module mdio_master #(
    parameter int MDC_DIV = 2
) (
    input  wire logic                   clk_125mhz,
    input  wire logic                   rst_125mhz,

    input  wire logic                   cmd_valid,
    output wire logic                   cmd_ready,
    input  wire stats_pkg::mdio_frame_t cmd_frame,

    output wire logic                   phy_mdc,
    output wire logic                   phy_mdio_o,
    output wire logic                   phy_mdio_t
);

localparam int DIV_W = (MDC_DIV > 1) ? $clog2(MDC_DIV) : 1;

logic busy_reg;
logic mdc_reg;
logic mdio_o_reg;
logic [DIV_W-1:0] div_cnt_reg;
logic [5:0] bit_cnt_reg;
logic [63:0] shift_reg;

logic tick;
logic start;

// end of an MDC half period
assign tick = div_cnt_reg == DIV_W'(MDC_DIV - 1);
assign start = !busy_reg && cmd_valid;

always_ff @(posedge clk_125mhz) begin
    if (busy_reg) begin
        if (tick) begin
            div_cnt_reg <= '0;
            mdc_reg <= !mdc_reg;
            if (mdc_reg) begin
                // falling edge, move to next bit
                bit_cnt_reg <= bit_cnt_reg - 1'b1;
                mdio_o_reg <= shift_reg[62];
                if (bit_cnt_reg == '0) begin
                    busy_reg <= 1'b0;
                    mdio_o_reg <= 1'b1;
                end
            end
        end else begin
            div_cnt_reg <= div_cnt_reg + 1'b1;
        end
    end else if (start) begin
        busy_reg <= 1'b1;
        div_cnt_reg <= '0;
        mdc_reg <= 1'b0;
        bit_cnt_reg <= 6'd63;
        // first preamble bit
        mdio_o_reg <= 1'b1;
    end

    if (rst_125mhz) begin
        busy_reg <= 1'b0;
        mdc_reg <= 1'b0;
        mdio_o_reg <= 1'b1;
        div_cnt_reg <= '0;
        bit_cnt_reg <= '0;
    end
end

// 32 preamble ones, then the raw frame
always_ff @(posedge clk_125mhz) begin
    if (start) begin
        shift_reg <= {32'hFFFF_FFFF, cmd_frame.raw};
    end else if (busy_reg && tick && mdc_reg) begin
        shift_reg <= shift_reg << 1;
    end
end

assign cmd_ready = !busy_reg;
assign phy_mdc = mdc_reg;
assign phy_mdio_o = mdio_o_reg;
assign phy_mdio_t = !busy_reg;

endmodule

`default_nettype wire

// File: logic/mgmt_core.sv
// mgmt_core: statistics counters and PHY MDIO init top level
`timescale 1ns/1ns
`default_nettype none

module mgmt_core #(
    parameter int INIT_DELAY = 1000000,
    parameter int MDC_DIV = 2
) (
    input  wire logic                                                   clk_125mhz,
    input  wire logic                                                   rst_125mhz,

    // statistics sources
    input  wire logic [stats_pkg::STAT_SOURCES-1:0]                     stat_valid,
    output wire logic [stats_pkg::STAT_SOURCES-1:0]                     stat_ready,
    input  wire logic [stats_pkg::STAT_SOURCES-1:0][stats_pkg::STAT_ID_W-1:0]  stat_id,
    input  wire logic [stats_pkg::STAT_SOURCES-1:0][stats_pkg::STAT_INC_W-1:0] stat_inc,

    // AXI4-Lite read channel
    input  wire logic [stats_pkg::AXIL_ADDR_W-1:0]                      s_axil_araddr,
    input  wire logic                                                   s_axil_arvalid,
    output wire logic                                                   s_axil_arready,
    output wire logic [stats_pkg::STAT_COUNT_W-1:0]                     s_axil_rdata,
    output wire logic [1:0]                                             s_axil_rresp,
    output wire logic                                                   s_axil_rvalid,
    input  wire logic                                                   s_axil_rready,

    // PHY management
    output wire logic                                                   phy_reset_n,
    output wire logic                                                   phy_mdc,
    output wire logic                                                   phy_mdio_o,
    output wire logic                                                   phy_mdio_t
);

import stats_pkg::*;

wire logic arb_valid;
wire logic arb_ready;
wire logic [STAT_ID_W-1:0] arb_id;
wire logic [STAT_INC_W-1:0] arb_inc;

wire logic cmd_valid;
wire logic cmd_ready;
wire mdio_frame_t cmd_frame;

assign phy_reset_n = !rst_125mhz;

stat_rr_arbiter stat_arb_inst (
    .clk_125mhz(clk_125mhz),
    .rst_125mhz(rst_125mhz),
    .stat_valid(stat_valid),
    .stat_ready(stat_ready),
    .stat_id(stat_id),
    .stat_inc(stat_inc),
    .arb_valid(arb_valid),
    .arb_ready(arb_ready),
    .arb_id(arb_id),
    .arb_inc(arb_inc)
);

stat_counter_mem stat_mem_inst (
    .clk_125mhz(clk_125mhz),
    .rst_125mhz(rst_125mhz),
    .arb_valid(arb_valid),
    .arb_ready(arb_ready),
    .arb_id(arb_id),
    .arb_inc(arb_inc),
    .s_axil_araddr(s_axil_araddr),
    .s_axil_arvalid(s_axil_arvalid),
    .s_axil_arready(s_axil_arready),
    .s_axil_rdata(s_axil_rdata),
    .s_axil_rresp(s_axil_rresp),
    .s_axil_rvalid(s_axil_rvalid),
    .s_axil_rready(s_axil_rready)
);

phy_init_sequencer #(
    .INIT_DELAY(INIT_DELAY)
) phy_init_inst (
    .clk_125mhz(clk_125mhz),
    .rst_125mhz(rst_125mhz),
    .cmd_valid(cmd_valid),
    .cmd_ready(cmd_ready),
    .cmd_frame(cmd_frame)
);

// 125 MHz / (2 * MDC_DIV) on MDC
mdio_master #(
    .MDC_DIV(MDC_DIV)
) mdio_master_inst (
    .clk_125mhz(clk_125mhz),
    .rst_125mhz(rst_125mhz),
    .cmd_valid(cmd_valid),
    .cmd_ready(cmd_ready),
    .cmd_frame(cmd_frame),
    .phy_mdc(phy_mdc),
    .phy_mdio_o(phy_mdio_o),
    .phy_mdio_t(phy_mdio_t)
);

endmodule

`default_nettype wire

// File: dv/mgmt_core_sva.sv
// concurrent assertions on the AXI4-Lite read handshake and the MDIO idle state, with bind
`timescale 1ns/1ns
`default_nettype none

module mgmt_core_sva (
    input  wire logic                               clk_125mhz,
    input  wire logic                               rst_125mhz,
    input  wire logic                               s_axil_arvalid,
    input  wire logic                               s_axil_arready,
    input  wire logic [stats_pkg::STAT_COUNT_W-1:0] s_axil_rdata,
    input  wire logic                               s_axil_rvalid,
    input  wire logic                               s_axil_rready,
    input  wire logic                               cmd_ready,
    input  wire logic                               phy_mdc,
    input  wire logic                               phy_mdio_o,
    input  wire logic                               phy_mdio_t
);

int fail_count = 0;
logic resp_open_reg;

// open from the AR handshake until the R handshake
always_ff @(posedge clk_125mhz) begin
    if (s_axil_rvalid && s_axil_rready) begin
        resp_open_reg <= 1'b0;
    end
    if (s_axil_arvalid && s_axil_arready) begin
        resp_open_reg <= 1'b1;
    end
    if (rst_125mhz) begin
        resp_open_reg <= 1'b0;
    end
end

r_hold_a: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
    s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid && $stable(s_axil_rdata))
    else begin
        $error("read response dropped or changed before rready");
        fail_count++;
    end

no_ar_pending_a: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
    resp_open_reg |-> !(s_axil_arvalid && s_axil_arready))
    else begin
        $error("AR handshake while a read response is pending");
        fail_count++;
    end

// mdio released high and MDC parked low whenever the master can take a command
mdio_idle_a: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
    cmd_ready |-> phy_mdio_t && phy_mdio_o && !phy_mdc)
    else begin
        $error("MDIO driven or MDC running while the master is idle");
        fail_count++;
    end

endmodule

bind mgmt_core mgmt_core_sva sva_i (
    .clk_125mhz(clk_125mhz),
    .rst_125mhz(rst_125mhz),
    .s_axil_arvalid(s_axil_arvalid),
    .s_axil_arready(s_axil_arready),
    .s_axil_rdata(s_axil_rdata),
    .s_axil_rvalid(s_axil_rvalid),
    .s_axil_rready(s_axil_rready),
    .cmd_ready(cmd_ready),
    .phy_mdc(phy_mdc),
    .phy_mdio_o(phy_mdio_o),
    .phy_mdio_t(phy_mdio_t)
);

`default_nettype wire

// File: dv/mgmt_core_tb.sv
// mgmt_core testbench with case-file replay, counter model, MDIO frame decoder and watchdog
`timescale 1ns/1ns
`default_nettype none

module mgmt_core_tb;

localparam int INIT_DELAY = 100;
localparam int MDC_DIV = 2;
localparam int SOURCES = 3;
localparam int MAX_CASES = 64;
localparam int MAX_PEND = 8;

// PHY init write data in programming order, registers alternate REGCR/ADDAR
localparam logic [15:0] init_data [12] = '{
    16'h001F, 16'h0031, 16'h401F, 16'h0070,
    16'h001F, 16'h00D3, 16'h401F, 16'h4000,
    16'h001F, 16'h016F, 16'h401F, 16'h0015
};

logic clk_125mhz = 1'b0;
logic rst_125mhz;
logic [SOURCES-1:0] stat_valid;
logic [SOURCES-1:0] stat_ready;
logic [SOURCES-1:0][5:0] stat_id;
logic [SOURCES-1:0][15:0] stat_inc;
logic [7:0] s_axil_araddr;
logic s_axil_arvalid;
logic s_axil_arready;
logic [31:0] s_axil_rdata;
logic [1:0] s_axil_rresp;
logic s_axil_rvalid;
logic s_axil_rready;
logic phy_reset_n;
logic phy_mdc;
logic phy_mdio_o;
logic phy_mdio_t;

int error_count = 0;
int check_count = 0;
logic [31:0] model [64];

// parsed case file
int ncase = 0;
bit case_is_read [MAX_CASES];
logic [31:0] case_a [MAX_CASES];
logic [31:0] case_b [MAX_CASES];
logic [31:0] case_c [MAX_CASES];
logic [31:0] case_d [MAX_CASES];

// increments waiting for the next burst, per source
logic [5:0] pend_id [SOURCES][MAX_PEND];
logic [15:0] pend_inc [SOURCES][MAX_PEND];
int pend_rep [SOURCES][MAX_PEND];
int pend_n [SOURCES];

logic [63:0] mdio_sr = '0;
int mdio_bits = 0;
int frame_count = 0;

int fd;
int n;
int src;
int total_items;
int limit_cycles;
logic [8*8-1:0] kind;
logic [8*256-1:0] line;
logic [31:0] v_a;
logic [31:0] v_b;
logic [31:0] v_c;
logic [31:0] v_d;
logic [31:0] rd_data;

mgmt_core #(
    .INIT_DELAY(INIT_DELAY),
    .MDC_DIV(MDC_DIV)
) dut_i (
    .clk_125mhz(clk_125mhz),
    .rst_125mhz(rst_125mhz),
    .stat_valid(stat_valid),
    .stat_ready(stat_ready),
    .stat_id(stat_id),
    .stat_inc(stat_inc),
    .s_axil_araddr(s_axil_araddr),
    .s_axil_arvalid(s_axil_arvalid),
    .s_axil_arready(s_axil_arready),
    .s_axil_rdata(s_axil_rdata),
    .s_axil_rresp(s_axil_rresp),
    .s_axil_rvalid(s_axil_rvalid),
    .s_axil_rready(s_axil_rready),
    .phy_reset_n(phy_reset_n),
    .phy_mdc(phy_mdc),
    .phy_mdio_o(phy_mdio_o),
    .phy_mdio_t(phy_mdio_t)
);

always #4 clk_125mhz = ~clk_125mhz;

task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("error at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
endtask

// one source replays its pending list, holding each item until ready
task automatic drive_source(input int s);
    for (int e = 0; e < pend_n[s]; e++) begin
        for (int r = 0; r < pend_rep[s][e]; r++) begin
            stat_valid[s] <= 1'b1;
            stat_id[s] <= pend_id[s][e];
            stat_inc[s] <= pend_inc[s][e];
            @(posedge clk_125mhz);
            while (!stat_ready[s]) begin
                @(posedge clk_125mhz);
            end
        end
    end
    stat_valid[s] <= 1'b0;
endtask

// all sources run at once until every pending increment is taken
task automatic flush_increments();
    @(posedge clk_125mhz);
    fork
        drive_source(0);
        drive_source(1);
        drive_source(2);
    join
    for (int s = 0; s < SOURCES; s++) begin
        pend_n[s] = 0;
    end
endtask

task automatic axil_read(input logic [7:0] addr, input int stall, output logic [31:0] data);
    int lat;
    @(posedge clk_125mhz);
    s_axil_araddr <= addr;
    s_axil_arvalid <= 1'b1;
    s_axil_rready <= (stall == 0);
    @(posedge clk_125mhz);
    while (!s_axil_arready) begin
        @(posedge clk_125mhz);
    end
    s_axil_arvalid <= 1'b0;
    lat = 1;
    @(posedge clk_125mhz);
    while (!s_axil_rvalid) begin
        @(posedge clk_125mhz);
        lat++;
    end
    check_value(lat, 2, $sformatf("rvalid latency for 0x%0h", addr));
    check_value(s_axil_rresp, 2'b00, "rresp");
    data = s_axil_rdata;
    if (stall > 0) begin
        // a second request has to wait while the response is held
        s_axil_arvalid <= 1'b1;
        repeat (stall) begin
            @(posedge clk_125mhz);
            check_value(s_axil_rvalid, 1'b1, "rvalid held under back-pressure");
            check_value(s_axil_rdata, data, "rdata held under back-pressure");
            check_value(s_axil_arready, 1'b0, "arready while a response is pending");
        end
        s_axil_arvalid <= 1'b0;
        s_axil_rready <= 1'b1;
        @(posedge clk_125mhz);
        check_value(s_axil_rvalid, 1'b1, "rvalid at the late handshake");
    end
endtask

// clause 22 write is 32 ones, then 01, 01, PHY 3, register, 10 and data
task automatic check_frame(input logic [63:0] bits);
    string tag;
    tag = $sformatf("MDIO frame %0d", frame_count);
    check_value(bits[63:32], 32'hFFFF_FFFF, {tag, " preamble"});
    check_value(bits[31:30], 2'b01, {tag, " start"});
    check_value(bits[29:28], 2'b01, {tag, " opcode"});
    check_value(bits[27:23], 5'd3, {tag, " PHY address"});
    check_value(bits[17:16], 2'b10, {tag, " turnaround"});
    if (frame_count < 12) begin
        check_value(bits[22:18], (frame_count % 2 == 0) ? 5'h0D : 5'h0E, {tag, " register"});
        check_value(bits[15:0], init_data[frame_count], {tag, " data"});
    end
    frame_count++;
endtask

// mdio sampled on rising MDC while driven
always @(posedge phy_mdc) begin
    if (!phy_mdio_t) begin
        mdio_sr = {mdio_sr[62:0], phy_mdio_o};
        mdio_bits++;
        if (mdio_bits == 64) begin
            check_frame(mdio_sr);
            mdio_bits = 0;
        end
    end
end

initial begin
    rst_125mhz = 1'b1;
    stat_valid = '0;
    stat_id = '0;
    stat_inc = '0;
    s_axil_araddr = '0;
    s_axil_arvalid = 1'b0;
    s_axil_rready = 1'b1;
    for (int i = 0; i < 64; i++) begin
        model[i] = '0;
    end
    for (int s = 0; s < SOURCES; s++) begin
        pend_n[s] = 0;
    end

    fd = $fopen("dv/stat_cases.txt", "r");
    if (fd == 0) begin
        $display("could not open the case file dv/stat_cases.txt");
        error_count++;
    end else begin
        while (!$feof(fd) && ncase < MAX_CASES) begin
            kind = '0;
            n = $fscanf(fd, "%s", kind);
            if (n == 1 && kind == "#") begin
                n = $fgets(line, fd);
            end else if (n == 1 && (kind == "inc" || kind == "rd")) begin
                v_d = 1;
                if (kind == "inc") begin
                    n = $fscanf(fd, "%d %h %h %d", v_a, v_b, v_c, v_d);
                end else begin
                    n = $fscanf(fd, "%h %h %d", v_a, v_b, v_c);
                end
                case_is_read[ncase] = (kind == "rd");
                case_a[ncase] = v_a;
                case_b[ncase] = v_b;
                case_c[ncase] = v_c;
                case_d[ncase] = v_d;
                ncase++;
            end else if (n == 1) begin
                $display("unknown line kind in the case file");
                error_count++;
            end
        end
        $fclose(fd);
    end

    // 64 clear reads plus every replayed item
    total_items = 64;
    for (int i = 0; i < ncase; i++) begin
        total_items += case_is_read[i] ? 1 : int'(case_d[i]);
    end
    limit_cycles = total_items * 40 + INIT_DELAY + 12 * 64 * 4 * MDC_DIV + 500;

    fork
        begin
            repeat (limit_cycles) @(posedge clk_125mhz);
            $display("timeout: the run did not finish within %0d cycles", limit_cycles);
            $display("** FAIL **");
            $finish;
        end
    join_none

    repeat (2) @(posedge clk_125mhz);
    check_value(stat_ready, 3'b000, "stat_ready in reset");
    check_value(s_axil_arready, 1'b0, "arready in reset");
    check_value(s_axil_rvalid, 1'b0, "rvalid in reset");
    check_value(phy_mdc, 1'b0, "MDC in reset");
    check_value(phy_mdio_t, 1'b1, "mdio_t in reset");
    check_value(phy_reset_n, 1'b0, "phy_reset_n in reset");
    rst_125mhz <= 1'b0;
    @(posedge clk_125mhz);
    check_value(phy_reset_n, 1'b1, "phy_reset_n after reset");

    for (int i = 0; i < 64; i++) begin
        axil_read(8'(i * 4), 0, rd_data);
        check_value(rd_data, model[i], $sformatf("counter %0d after clear", i));
    end

    for (int i = 0; i < ncase; i++) begin
        if (!case_is_read[i]) begin
            src = case_a[i];
            if (pend_n[src] == MAX_PEND) begin
                flush_increments();
            end
            pend_id[src][pend_n[src]] = case_b[i][5:0];
            pend_inc[src][pend_n[src]] = case_c[i][15:0];
            pend_rep[src][pend_n[src]] = case_d[i];
            pend_n[src]++;
            model[case_b[i][5:0]] = model[case_b[i][5:0]] + case_c[i] * case_d[i];
        end else begin
            flush_increments();
            check_value(model[case_a[i][7:2]], case_b[i],
                $sformatf("case file value for 0x%0h", case_a[i][7:0]));
            axil_read(case_a[i][7:0], case_c[i], rd_data);
            check_value(rd_data, case_b[i], $sformatf("counter read at 0x%0h", case_a[i][7:0]));
        end
    end
    flush_increments();

    while (frame_count < 12) begin
        @(posedge clk_125mhz);
    end
    // room for a thirteenth frame to show up
    repeat (64 * 4 * MDC_DIV) @(posedge clk_125mhz);
    check_value(frame_count, 12, "MDIO frame count");

    $display("checks: %0d, value errors: %0d, assertion failures: %0d",
        check_count, error_count, dut_i.sva_i.fail_count);
    if (error_count == 0 && dut_i.sva_i.fail_count == 0) begin
        $display("** PASS **");
    end else begin
        $display("** FAIL **");
    end
    $finish;
end

endmodule

`default_nettype wire

// File: dv/stat_cases.txt
# inc <source> <id hex> <amount hex> <repeat count>
# rd <byte address hex> <expected value hex> <rready stall cycles>
# one source accumulating into counter 1
inc 0 01 0010 1
inc 0 01 0020 3
rd 04 00000070 0
# counter 5 wraps past 2^32
inc 1 05 ffff 65538
rd 14 0000fffe 0
# all three sources at once on the same id
inc 0 0a 0001 4
inc 1 0a 0100 4
inc 2 0a 1000 4
inc 2 0b 0003 2
rd 28 00004404 0
rd 2c 00000006 0
# mixed ids from all sources
inc 0 02 0007 5
inc 1 03 0009 5
inc 2 02 0001 5
rd 08 00000028 0
rd 0c 0000002d 0
# held responses, then neighbouring counters
inc 0 3f abcd 1
inc 1 3e 1234 2
rd fc 0000abcd 5
rd f8 00002468 3
rd 04 00000070 0
rd 00 00000000 0

// File: project.f
logic/stats_pkg.sv
logic/stat_rr_arbiter.sv
logic/stat_counter_mem.sv
logic/phy_init_sequencer.sv
logic/mdio_master.sv
logic/mgmt_core.sv
dv/mgmt_core_sva.sv
dv/mgmt_core_tb.sv
